//--- src.f
src/conspiracion_pkg.sv
src/debounce.sv
src/onchip_ram.sv
src/pio_port.sv
src/interval_timer.sv
src/platform.sv
src/conspiracion.sv
sim/conspiracion_assert.sv
sim/conspiracion_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = conspiracion_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+100
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/conspiracion_tb.sv
`timescale 1ns/1ps

module conspiracion_tb
import conspiracion_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 4000; // About twelve times the full run.
	localparam int SETTLE_CYCLES = 25;    // Past the 18-cycle debounce path.
	localparam int TIMER_N = 20;

	logic clk = 1'b0;
	logic reset, pio_buttons, bus_write, bus_start, bus_ready, irq;
	logic [5:0] pio_switches;
	logic [7:0] pio_leds;
	logic [29:0] bus_addr;
	logic [31:0] bus_data_wr, bus_data_rd;
	logic [3:0] bus_data_be;

	logic [31:0] ram_model[RAM_WORDS];
	int errors = 0, cycles = 0, tests = 0, failed_tests = 0, test_errors = 0;

	always #20 clk = ~clk;

	conspiracion u_dut (.clk_clk(clk), .*);

	bind conspiracion conspiracion_assert u_assert (
		.clk_clk(clk_clk),
		.reset(reset),
		.bus_start(bus_start),
		.bus_ready(bus_ready),
		.irq(irq)
	);

	////////////////////
	// Helpers
	////////////////////

	task automatic check_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic transfer(input logic wr, input logic [3:0] region,
			input logic [25:0] offset, input logic [31:0] wdata, input logic [3:0] be,
			output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk);
		bus_addr = {region, offset};
		bus_write = wr;
		bus_data_wr = wdata;
		bus_data_be = be;
		bus_start = 1'b1;
		@(negedge clk);
		bus_start = 1'b0;
		while (!bus_ready && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (!bus_ready) begin
			$display("Bus transfer at %0d ns got no ready within 8 cycles", $time);
			errors++;
		end
		rdata = bus_data_rd; // Valid while ready is high.
	endtask

	task automatic write_word(input logic [3:0] region, input logic [25:0] offset,
			input logic [31:0] data, input logic [3:0] be);
		logic [31:0] ignored;
		transfer(1'b1, region, offset, data, be, ignored);
	endtask

	task automatic expect_read(input string what, input logic [3:0] region,
			input logic [25:0] offset, input logic [31:0] exp);
		logic [31:0] got;
		transfer(1'b0, region, offset, 32'd0, 4'hf, got);
		check_equal(what, got, exp);
	endtask

	task automatic hold_input(input logic button, input logic [5:0] sw);
		@(negedge clk);
		pio_buttons = button;
		pio_switches = sw;
		repeat (SETTLE_CYCLES) @(negedge clk);
	endtask

	task automatic close_test(input string name);
		tests++;
		if (errors == test_errors)
			$display("Test %s: passed", name);
		else begin
			failed_tests++;
			$display("Test %s: failed with %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		logic [31:0] data;
		logic [RAM_ADDR_BITS-1:0] idx_list[16];
		logic [RAM_ADDR_BITS-1:0] idx;
		logic [3:0] be, region;
		logic [5:0] sw;
		logic [7:0] led_before;
		int k, total;

		void'($urandom(32'h54c267bd));
		reset = 1'b1;
		pio_buttons = 1'b1; // Released, the button is active low.
		pio_switches = 6'd0;
		bus_addr = 30'd0;
		bus_data_wr = 32'd0;
		bus_data_be = 4'd0;
		bus_write = 1'b0;
		bus_start = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// Full words first, so that every word read back is defined.
		for (int i = 0; i < 16; i++) begin
			idx_list[i] = RAM_ADDR_BITS'($urandom);
			data = $urandom;
			write_word(REGION_RAM, 26'(idx_list[i]), data, 4'hf);
			ram_model[idx_list[i]] = data;
		end
		for (int i = 0; i < 16; i++) begin
			idx = idx_list[$urandom % 16];
			data = $urandom;
			be = 4'($urandom);
			write_word(REGION_RAM, 26'(idx), data, be);
			for (int b = 0; b < 4; b++)
				if (be[b])
					ram_model[idx][8*b +: 8] = data[8*b +: 8];
		end
		for (int i = 0; i < 16; i++)
			expect_read("RAM word", REGION_RAM, 26'(idx_list[i]), ram_model[idx_list[i]]);
		close_test("ram");

		for (int i = 0; i < 4; i++) begin
			data = $urandom;
			write_word(REGION_PIO, 26'(PIO_LEDS), data, 4'b0001);
			check_equal("LED pins", 32'(pio_leds), 32'(data[7:0]));
			write_word(REGION_PIO, 26'(PIO_LEDS), ~data, 4'b1110); // Misses byte 0.
			expect_read("LED register", REGION_PIO, 26'(PIO_LEDS), {24'd0, data[7:0]});
		end
		for (int i = 0; i < 3; i++) begin
			sw = 6'($urandom);
			hold_input(1'b1, sw);
			expect_read("switches", REGION_PIO, 26'(PIO_SWITCHES), {26'd0, sw});
		end
		close_test("leds_switches");

		expect_read("button idle", REGION_PIO, 26'(PIO_BUTTONS), 32'd0);
		hold_input(1'b0, sw);
		expect_read("button pressed", REGION_PIO, 26'(PIO_BUTTONS), 32'd3);
		check_equal("irq while masked", 32'(irq), 32'd0);
		write_word(REGION_PIO, 26'(PIO_IRQ_MASK), 32'd1, 4'b0001);
		check_equal("irq after mask", 32'(irq), 32'd1);
		hold_input(1'b1, sw);
		expect_read("button released", REGION_PIO, 26'(PIO_BUTTONS), 32'd2);
		write_word(REGION_PIO, 26'(PIO_BUTTONS), 32'd2, 4'b0001);
		check_equal("irq after press clear", 32'(irq), 32'd0);
		expect_read("button cleared", REGION_PIO, 26'(PIO_BUTTONS), 32'd0);
		close_test("button");

		write_word(REGION_TIMER, 26'(TIMER_LOAD), TIMER_N, 4'hf);
		write_word(REGION_TIMER, 26'(TIMER_CTRL), 32'd3, 4'b0001);
		k = 0;
		while (!irq && k <= TIMER_N + 3) begin
			@(negedge clk);
			k++;
		end
		assert (k > TIMER_N && k <= TIMER_N + 3)
		else begin
			$display("[ERROR] %0d ns: timer expired after %0d cycles, expected %0d to %0d",
				$time, k, TIMER_N + 1, TIMER_N + 3);
			errors++;
		end
		expect_read("timer status", REGION_TIMER, 26'(TIMER_STATUS), 32'd1);
		write_word(REGION_TIMER, 26'(TIMER_STATUS), 32'd1, 4'b0001);
		check_equal("irq after timer clear", 32'(irq), 32'd0);
		expect_read("timer status cleared", REGION_TIMER, 26'(TIMER_STATUS), 32'd0);
		write_word(REGION_TIMER, 26'(TIMER_CTRL), 32'd0, 4'b0001);
		close_test("timer");

		region = 4'(3 + ($urandom % 13));
		expect_read("unmapped read", region, 26'd0, 32'd0);
		led_before = pio_leds;
		write_word(region, 26'(idx_list[0]), ~ram_model[idx_list[0]], 4'hf);
		write_word(region, 26'(PIO_LEDS), {24'd0, ~led_before}, 4'hf);
		check_equal("LED pins after unmapped write", 32'(pio_leds), 32'(led_before));
		expect_read("RAM after unmapped write", REGION_RAM, 26'(idx_list[0]),
			ram_model[idx_list[0]]);
		close_test("unmapped");

		total = errors + u_dut.u_assert.fail_count;
		$display("Tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
			tests, failed_tests, errors, u_dut.u_assert.fail_count);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- sim/conspiracion_assert.sv
`timescale 1ns/1ps

module conspiracion_assert
(
	input logic clk_clk,
	input logic reset,
	input logic bus_start,
	input logic bus_ready,
	input logic irq
);

	int fail_count = 0;

	// Every transfer is answered on the very next edge.
	ready_after_start: assert property (@(posedge clk_clk) disable iff (reset)
		bus_start |=> bus_ready)
	else begin
		$error("ready did not follow start by one cycle");
		fail_count++;
	end

	ready_one_cycle: assert property (@(posedge clk_clk) disable iff (reset)
		bus_ready |=> !bus_ready)
	else begin
		$error("ready stayed high for more than one cycle");
		fail_count++;
	end

	ready_needs_start: assert property (@(posedge clk_clk) disable iff (reset)
		$rose(bus_ready) |-> $past(bus_start))
	else begin
		$error("ready rose without a start");
		fail_count++;
	end

	// The first edge of reset still shows the power-up values.
	quiet_in_reset: assert property (@(posedge clk_clk)
		reset && $past(reset) |-> !bus_ready && !irq)
	else begin
		$error("ready or irq high during reset");
		fail_count++;
	end

endmodule

//--- src/conspiracion.sv
`timescale 1ns/1ps

module conspiracion
(
	input  logic        clk_clk,
	input  logic        reset,
	input  logic        pio_buttons,
	input  logic [5:0]  pio_switches,
	output logic [7:0]  pio_leds,
	input  logic [29:0] bus_addr,
	input  logic [31:0] bus_data_wr,
	input  logic [3:0]  bus_data_be,
	input  logic        bus_write,
	input  logic        bus_start,
	output logic [31:0] bus_data_rd,
	output logic        bus_ready,
	output logic        irq
);

	logic button;
	logic [5:0] switches;

	debounce #(.WIDTH(1)) button_debounce
	(
		.clk(clk_clk),
		.reset(reset),
		.dirty(pio_buttons),
		.clean(button)
	);

	debounce #(.WIDTH(6)) switch_debounce
	(
		.clk(clk_clk),
		.reset(reset),
		.dirty(pio_switches),
		.clean(switches)
	);

	// The bus port stands in for the missing core.
	platform plat
	(
		.clk(clk_clk),
		.reset(reset),
		.addr(bus_addr),
		.data_wr(bus_data_wr),
		.data_be(bus_data_be),
		.write(bus_write),
		.start(bus_start),
		.data_rd(bus_data_rd),
		.ready(bus_ready),
		.irq(irq),
		.leds(pio_leds),
		.switches(switches),
		.button(button)
	);

endmodule

//--- src/platform.sv
`timescale 1ns/1ps

module platform
import conspiracion_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic [29:0] addr,
	input  logic [31:0] data_wr,
	input  logic [3:0]  data_be,
	input  logic        write,
	input  logic        start,
	output logic [31:0] data_rd,
	output logic        ready,
	output logic        irq,
	output logic [7:0]  leds,
	input  logic [5:0]  switches,
	input  logic        button
);

	bus_addr_t bus;
	logic [3:0] region_q;
	logic [31:0] ram_rd, pio_rd, timer_rd;
	logic ram_sel, pio_sel, timer_sel, pio_irq, timer_irq;

	assign bus = addr;

	// Only one select can be high, and only in the start cycle.
	assign ram_sel = start && bus.fields.region == REGION_RAM;
	assign pio_sel = start && bus.fields.region == REGION_PIO;
	assign timer_sel = start && bus.fields.region == REGION_TIMER;

	always_ff @(posedge clk) begin
		if (reset) begin
			ready <= 1'b0;
			region_q <= REGION_RAM;
		end else begin
			ready <= start; // Every device answers one cycle after start.
			if (start)
				region_q <= bus.fields.region;
		end
	end

	always_comb begin
		case (region_q)
			REGION_RAM:   data_rd = ram_rd;
			REGION_PIO:   data_rd = pio_rd;
			REGION_TIMER: data_rd = timer_rd;
			default:      data_rd = 32'd0; // Unmapped reads come back as zero.
		endcase
	end

	////////////////////
	// Devices
	////////////////////

	onchip_ram ram
	(
		.clk(clk),
		.sel(ram_sel),
		.write(write),
		.index(bus.word[RAM_ADDR_BITS-1:0]),
		.data_be(data_be),
		.data_wr(data_wr),
		.data_rd(ram_rd)
	);

	pio_port pio
	(
		.clk(clk),
		.reset(reset),
		.sel(pio_sel),
		.write(write),
		.offset(bus.fields.offset[1:0]),
		.data_be(data_be),
		.data_wr(data_wr),
		.data_rd(pio_rd),
		.leds(leds),
		.switches(switches),
		.button(button),
		.irq(pio_irq)
	);

	interval_timer timer
	(
		.clk(clk),
		.reset(reset),
		.sel(timer_sel),
		.write(write),
		.offset(bus.fields.offset[1:0]),
		.data_be(data_be),
		.data_wr(data_wr),
		.data_rd(timer_rd),
		.irq(timer_irq)
	);

	assign irq = pio_irq || timer_irq;

endmodule

//--- src/interval_timer.sv
`timescale 1ns/1ps

module interval_timer
import conspiracion_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        sel,
	input  logic        write,
	input  logic [1:0]  offset,
	input  logic [3:0]  data_be,
	input  logic [31:0] data_wr,
	output logic [31:0] data_rd,
	output logic        irq
);

	logic [31:0] load, load_next, count;
	logic enable, irq_en, expired, wr_sel;

	assign wr_sel = sel && write;

	// Merge the enabled bytes so the count can be loaded with the new value.
	always_comb begin
		load_next = load;
		for (int i = 0; i < 4; i++)
			if (data_be[i])
				load_next[8*i +: 8] = data_wr[8*i +: 8];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			load <= 32'd0;
			count <= 32'd0;
			enable <= 1'b0;
			irq_en <= 1'b0;
			expired <= 1'b0;
		end else begin
			if (wr_sel && offset == TIMER_LOAD) begin
				load <= load_next;
				count <= load_next;
			end else if (enable) begin
				if (count == 32'd0)
					count <= load; // Wraps back to the load value.
				else
					count <= count - 32'd1;
			end

			if (wr_sel && offset == TIMER_CTRL && data_be[0]) begin
				enable <= data_wr[0];
				irq_en <= data_wr[1];
			end

			if (enable && count == 32'd0 && !(wr_sel && offset == TIMER_LOAD))
				expired <= 1'b1;
			else if (wr_sel && offset == TIMER_STATUS && data_be[0] && data_wr[0])
				expired <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sel) begin
			case (offset)
				TIMER_LOAD:   data_rd <= load;
				TIMER_CTRL:   data_rd <= {30'd0, irq_en, enable};
				TIMER_COUNT:  data_rd <= count;
				TIMER_STATUS: data_rd <= {31'd0, expired};
				default:      data_rd <= 32'd0;
			endcase
		end
	end

	assign irq = expired && irq_en;

endmodule

//--- src/pio_port.sv
`timescale 1ns/1ps

module pio_port
import conspiracion_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        sel,
	input  logic        write,
	input  logic [1:0]  offset,
	input  logic [3:0]  data_be,
	input  logic [31:0] data_wr,
	output logic [31:0] data_rd,
	output logic [7:0]  leds,
	input  logic [5:0]  switches,
	input  logic        button,
	output logic        irq
);

	logic mask, pressed, button_prev, press_edge, wr_low;

	assign wr_low = sel && write && data_be[0];
	assign press_edge = button_prev && !button; // Active low, so a fall is a press.

	always_ff @(posedge clk) begin
		if (reset) begin
			leds <= 8'h00;
			mask <= 1'b0;
			pressed <= 1'b0;
			button_prev <= 1'b0; // The debouncer also comes out of reset low.
		end else begin
			button_prev <= button;

			if (wr_low && offset == PIO_LEDS)
				leds <= data_wr[7:0];

			if (wr_low && offset == PIO_IRQ_MASK)
				mask <= data_wr[0];

			// A press that lands on the clearing write still wins.
			if (press_edge)
				pressed <= 1'b1;
			else if (wr_low && offset == PIO_BUTTONS && data_wr[1])
				pressed <= 1'b0;
		end
	end

	////////////////////
	// Read back
	////////////////////

	always_ff @(posedge clk) begin
		if (sel) begin
			case (offset)
				PIO_LEDS:     data_rd <= {24'd0, leds};
				PIO_SWITCHES: data_rd <= {26'd0, switches};
				PIO_BUTTONS:  data_rd <= {30'd0, pressed, !button};
				PIO_IRQ_MASK: data_rd <= {31'd0, mask};
				default:      data_rd <= 32'd0;
			endcase
		end
	end

	assign irq = pressed && mask;

endmodule

//--- src/onchip_ram.sv
`timescale 1ns/1ps

module onchip_ram
import conspiracion_pkg::*;
(
	input  logic                     clk,
	input  logic                     sel,
	input  logic                     write,
	input  logic [RAM_ADDR_BITS-1:0] index,
	input  logic [3:0]               data_be,
	input  logic [31:0]              data_wr,
	output logic [31:0]              data_rd
);

	logic [31:0] mem[RAM_WORDS];

	always_ff @(posedge clk) begin
		if (sel) begin
			if (write) begin
				for (int i = 0; i < 4; i++)
					if (data_be[i])
						mem[index][8*i +: 8] <= data_wr[8*i +: 8];
			end

			// A write cycle returns the old word, which the master ignores.
			data_rd <= mem[index];
		end
	end

endmodule

//--- src/debounce.sv
`timescale 1ns/1ps

module debounce
import conspiracion_pkg::*;
#(
	parameter int WIDTH = 1
)
(
	input  logic             clk,
	input  logic             reset,
	input  logic [WIDTH-1:0] dirty,
	output logic [WIDTH-1:0] clean
);

	logic [WIDTH-1:0] sync_0, sync_1;
	logic [DEBOUNCE_COUNT_BITS-1:0] count[WIDTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_0 <= '0;
			sync_1 <= '0;
			clean <= '0;
			for (int i = 0; i < WIDTH; i++)
				count[i] <= '0;
		end else begin
			sync_0 <= dirty;
			sync_1 <= sync_0; // Two flops before anything looks at the bit.

			for (int i = 0; i < WIDTH; i++) begin
				if (sync_1[i] == clean[i])
					count[i] <= '0; // Any bounce back restarts the wait.
				else if (count[i] == DEBOUNCE_COUNT_BITS'(DEBOUNCE_CYCLES - 1)) begin
					clean[i] <= sync_1[i];
					count[i] <= '0;
				end else
					count[i] <= count[i] + 1'b1;
			end
		end
	end

endmodule

//--- src/conspiracion_pkg.sv
package conspiracion_pkg;

	////////////////////
	// Memory map
	////////////////////

	localparam logic [3:0] REGION_RAM   = 4'd0;
	localparam logic [3:0] REGION_PIO   = 4'd1;
	localparam logic [3:0] REGION_TIMER = 4'd2;

	localparam int RAM_WORDS     = 256;
	localparam int RAM_ADDR_BITS = 8;

	// PIO register offsets.
	localparam logic [1:0] PIO_LEDS     = 2'd0;
	localparam logic [1:0] PIO_SWITCHES = 2'd1;
	localparam logic [1:0] PIO_BUTTONS  = 2'd2;
	localparam logic [1:0] PIO_IRQ_MASK = 2'd3;

	// Interval timer register offsets.
	localparam logic [1:0] TIMER_LOAD   = 2'd0;
	localparam logic [1:0] TIMER_CTRL   = 2'd1;
	localparam logic [1:0] TIMER_COUNT  = 2'd2;
	localparam logic [1:0] TIMER_STATUS = 2'd3;

	localparam int DEBOUNCE_CYCLES     = 16; // Stable cycles before clean follows.
	localparam int DEBOUNCE_COUNT_BITS = $clog2(DEBOUNCE_CYCLES);

	////////////////////
	// Bus address views
	////////////////////

	typedef union packed {
		logic [29:0] word; // Full word index.
		struct packed {
			logic [3:0]  region;
			logic [25:0] offset;
		} fields;
	} bus_addr_t;

endpackage
